/* fe_top.f */
rtl/fe_pkg.sv
rtl/fe_fetch_if.sv
rtl/imem_fetch_buf.sv
rtl/bpu.sv
rtl/fe_ctl.sv
rtl/fe_decode_q.sv
rtl/fe_top.sv
verification/fe_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch front-end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module fe_top_tb \
    -f fe_top.f

# The simulator's own exit status is not trusted, the log decides
./obj_dir/Vfe_top_tb | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* verification/fe_top_tb.sv */
`timescale 1ns/1ps

module fe_top_tb
    import fe_pkg::*;
();

    localparam int     IMEM_AW     = 8;
    localparam int     QDEPTH      = 2;
    localparam t_paddr BOOT_PC     = 32'h0;
    localparam int     PROG_LEN    = 16;
    localparam int     NUM_EV      = 13;
    localparam int     EXP_COUNT   = 64;             // Instructions to deliver
    localparam int     MAX_CYCLES  = 40 * EXP_COUNT;
    localparam int     PARK_CYCLES = 6;              // Minimum stop before a resume

    // One redirect-side action, fired once the delivered count reaches at_count
    typedef struct packed {
        logic [7:0] at_count;
        logic       mis;
        t_rob_id    robid;
        t_paddr     restore_pc;
        t_rob_id    oldest;
        logic       nuke;
        logic       resume;
    } t_event;

    logic               clk                   = 1'b0;
    logic               reset                 = 1'b1;
    logic               imem_we               = 1'b0;
    logic [IMEM_AW-1:0] imem_waddr            = '0;
    t_rv_instr          imem_wdata            = '0;
    logic               br_mispred_valid      = 1'b0;
    t_rob_id            br_mispred_robid      = '0;
    t_paddr             br_mispred_restore_pc = '0;
    logic               nuke                  = 1'b0;
    logic               resume_fetch          = 1'b0;
    t_rob_id            oldest_robid          = '0;
    logic               dec_ready             = 1'b0;
    logic               dec_valid;
    t_rv_instr          dec_instr;
    t_paddr             dec_pc;
    t_paddr             dec_pc_nxt;

    t_rv_instr prog [PROG_LEN];
    t_event    events [NUM_EV];
    integer    seed = 32'h15cac6f3;
    int        errors = 0;
    int        checks = 0;
    int        delivered = 0;
    int        ev_idx = 0;
    int        cycles = 0;
    int        park_cycles = 0;
    logic      done = 1'b0;

    // Reference model state
    t_paddr    ref_pc = BOOT_PC;
    logic      ref_pdg = 1'b0;
    t_rob_id   ref_robid = '0;
    logic      parked = 1'b0;    // Between a redirect and its resume

    always #50 clk = ~clk;

    fe_top #(
        .IMEM_AW (IMEM_AW),
        .QDEPTH  (QDEPTH),
        .BOOT_PC (BOOT_PC)
    ) i_dut (
        .clk, .reset,
        .imem_we, .imem_waddr, .imem_wdata,
        .br_mispred_valid, .br_mispred_robid, .br_mispred_restore_pc,
        .nuke, .resume_fetch, .oldest_robid,
        .dec_valid, .dec_instr, .dec_pc, .dec_pc_nxt, .dec_ready
    );

    // addi x(i%32), x0, i
    function automatic t_rv_instr fill_word(input int idx);
        return (t_rv_instr'(idx) << 20) | (t_rv_instr'(idx % 32) << 7) | 32'h13;
    endfunction

    function automatic t_rv_instr jal_word(input int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic t_rv_instr branch_word(input int off, input logic [2:0] funct3,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
        logic [12:0] imm;
        imm = off[12:0];
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // Static rule: jal taken, backward branch taken, anything else falls through
    function automatic t_paddr predict_next(input t_rv_instr w, input t_paddr pc);
        t_paddr off;
        t_paddr nxt;
        nxt = pc + 32'd4;
        case (w[6:0])
            7'b1101111: begin
                off = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                nxt = pc + off;
            end
            7'b1100011: begin
                off = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                if (off[31]) nxt = pc + off;
            end
            default: nxt = pc + 32'd4;
        endcase
        return nxt;
    endfunction

    // Smaller distance from the oldest id means older
    function automatic logic is_older(input t_rob_id a, input t_rob_id b,
                                      input t_rob_id oldest);
        int dist_a;
        int dist_b;
        dist_a = (int'(a) - int'(oldest) + 16) % 16;
        dist_b = (int'(b) - int'(oldest) + 16) % 16;
        return dist_a < dist_b;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR: %s got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // Checks, model update and stimulus all happen on the same edge
    always @(posedge clk) begin : model_step
        logic   ql;
        t_paddr exp_nxt;
        dec_ready        <= ($random(seed) & 3) != 0;
        br_mispred_valid <= 1'b0;
        nuke             <= 1'b0;
        resume_fetch     <= 1'b0;
        if (!reset) begin
            if (dec_valid && dec_ready) begin
                if (parked) begin
                    errors++;
                    $display("Instruction at 0x%h delivered while waiting for resume", dec_pc);
                end else begin
                    exp_nxt = predict_next(prog[ref_pc[5:2]], ref_pc);
                    check_value("dec_pc", dec_pc, ref_pc);
                    check_value("dec_instr", dec_instr, prog[ref_pc[5:2]]);
                    check_value("dec_pc_nxt", dec_pc_nxt, exp_nxt);
                    ref_pc = exp_nxt;
                    delivered++;
                end
            end
            // Only the oldest mispredict redirects, a nuke forgets it
            ql = br_mispred_valid && (!ref_pdg || is_older(br_mispred_robid, ref_robid,
                                                            oldest_robid));
            if (ql) begin
                ref_pc    = br_mispred_restore_pc;
                ref_robid = br_mispred_robid;
            end
            ref_pdg = !nuke && (ref_pdg || ql);
            if (ql || nuke) begin
                parked      = 1'b1;
                park_cycles = 0;
            end else if (resume_fetch) begin
                parked = 1'b0;
            end else if (parked) begin
                park_cycles++;
            end

            // Resume only after a stop long enough for an early delivery to show
            if (ev_idx < NUM_EV && delivered >= int'(events[ev_idx].at_count) &&
                (!events[ev_idx].resume || park_cycles >= PARK_CYCLES)) begin
                br_mispred_valid      <= events[ev_idx].mis;
                br_mispred_robid      <= events[ev_idx].robid;
                br_mispred_restore_pc <= events[ev_idx].restore_pc;
                oldest_robid          <= events[ev_idx].oldest;
                nuke                  <= events[ev_idx].nuke;
                resume_fetch          <= events[ev_idx].resume;
                ev_idx++;
            end
            if (delivered >= EXP_COUNT) done = 1'b1;
        end
    end

    initial begin
        for (int i = 0; i < PROG_LEN; i++) prog[i] = fill_word(i);
        prog[2]  = jal_word(12);                           // To 0x14
        prog[5]  = branch_word(8, 3'b000, 5'd0, 5'd0);     // Forward beq, falls through
        prog[8]  = branch_word(-12, 3'b001, 5'd1, 5'd2);   // Backward bne to 0x14
        prog[12] = jal_word(-48);                          // Back to 0x00

        //           count  mis   robid  restore   oldest nuke  resume
        events[0]  = '{8'd12, 1'b1, 4'd5,  32'h24, 4'd0,  1'b0, 1'b0};
        events[1]  = '{8'd12, 1'b1, 4'd9,  32'h10, 4'd0,  1'b0, 1'b0};  // Younger, ignored
        events[2]  = '{8'd12, 1'b0, 4'd0,  32'h0,  4'd0,  1'b0, 1'b1};
        events[3]  = '{8'd20, 1'b1, 4'd3,  32'h0c, 4'd0,  1'b0, 1'b0};  // Older, replaces
        events[4]  = '{8'd20, 1'b1, 4'd7,  32'h10, 4'd0,  1'b0, 1'b0};
        events[5]  = '{8'd20, 1'b0, 4'd0,  32'h0,  4'd0,  1'b0, 1'b1};
        events[6]  = '{8'd30, 1'b1, 4'd4,  32'h30, 4'd0,  1'b0, 1'b0};  // Ignored while running
        events[7]  = '{8'd34, 1'b0, 4'd0,  32'h0,  4'd2,  1'b1, 1'b0};
        events[8]  = '{8'd34, 1'b1, 4'd14, 32'h30, 4'd2,  1'b0, 1'b0};  // Accepted after nuke
        events[9]  = '{8'd34, 1'b0, 4'd0,  32'h0,  4'd2,  1'b0, 1'b1};
        events[10] = '{8'd44, 1'b1, 4'd1,  32'h20, 4'd14, 1'b0, 1'b0};  // Younger across wrap
        events[11] = '{8'd50, 1'b1, 4'd13, 32'h04, 4'd12, 1'b0, 1'b0};
        events[12] = '{8'd50, 1'b0, 4'd0,  32'h0,  4'd12, 1'b0, 1'b1};

        // Program goes in under reset, then four more reset cycles
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_waddr <= IMEM_AW'(i);
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (4) @(posedge clk);
        check_value("dec_valid", {31'b0, dec_valid}, 32'h0);  // Queue empty under reset
        reset <= 1'b0;

        while (!done && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("Timeout after %0d cycles with %0d of %0d instructions delivered",
                     cycles, delivered, EXP_COUNT);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* rtl/fe_top.sv */
`timescale 1ns/1ps

module fe_top
    import fe_pkg::*;
#(
    parameter int     IMEM_AW = 8,
    parameter int     QDEPTH  = 2,
    parameter t_paddr BOOT_PC = 32'h0
) (
    input  logic               clk,
    input  logic               reset,

    input  logic               imem_we,
    input  logic [IMEM_AW-1:0] imem_waddr,
    input  t_rv_instr          imem_wdata,

    input  logic               br_mispred_valid,
    input  t_rob_id            br_mispred_robid,
    input  t_paddr             br_mispred_restore_pc,
    input  logic               nuke,
    input  logic               resume_fetch,
    input  t_rob_id            oldest_robid,

    output logic               dec_valid,
    output t_rv_instr          dec_instr,
    output t_paddr             dec_pc,
    output t_paddr             dec_pc_nxt,
    input  logic               dec_ready
);

    fe_fetch_if fetch_if ();

    logic       valid_fe1;
    logic       ready_fe1;
    logic       flush;
    t_instr_pkt instr_fe1;
    t_instr_pkt dec_pkt;

    imem_fetch_buf #(.IMEM_AW(IMEM_AW)) u_imem (
        .clk, .reset,
        .imem_we, .imem_waddr, .imem_wdata,
        .fetch (fetch_if.fbuf)
    );

    fe_ctl #(.BOOT_PC(BOOT_PC)) u_fe_ctl (
        .clk, .reset,
        .fetch (fetch_if.ctl),
        .br_mispred_valid, .br_mispred_robid, .br_mispred_restore_pc,
        .nuke, .resume_fetch, .oldest_robid,
        .valid_fe1, .instr_fe1, .ready_fe1, .flush
    );

    fe_decode_q #(.QDEPTH(QDEPTH)) u_decode_q (
        .clk, .reset, .flush,
        .in_valid  (valid_fe1),
        .in_pkt    (instr_fe1),
        .in_ready  (ready_fe1),
        .out_valid (dec_valid),
        .out_pkt   (dec_pkt),
        .out_ready (dec_ready)
    );

    assign dec_instr  = dec_pkt.instr;
    assign dec_pc     = dec_pkt.pc;
    assign dec_pc_nxt = dec_pkt.pc_nxt;

endmodule

/* rtl/fe_decode_q.sv */
`timescale 1ns/1ps

// Small registered FIFO between fetch and the decoder
module fe_decode_q
    import fe_pkg::*;
#(
    parameter int QDEPTH = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,

    input  logic       in_valid,
    input  t_instr_pkt in_pkt,
    output logic       in_ready,

    output logic       out_valid,
    output t_instr_pkt out_pkt,
    input  logic       out_ready
);

    localparam int PW = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
    localparam int CW = $clog2(QDEPTH + 1);

    t_instr_pkt    mem [QDEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(QDEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = count != CW'(QDEPTH);  // Not full
    assign out_valid = count != '0;
    assign out_pkt   = mem[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (reset | flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CW'(push) - CW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_pkt;
    end

    // Full means the write pointer has caught up with the oldest entry
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        count <= CW'(QDEPTH) && (count != CW'(QDEPTH) || wr_ptr == rd_ptr)
    ) else $error("decode queue overflow");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset)
        (count == '0) |-> wr_ptr == rd_ptr
    ) else $error("decode queue underflow");

endmodule

/* rtl/fe_ctl.sv */
`timescale 1ns/1ps

module fe_ctl
    import fe_pkg::*;
#(
    parameter t_paddr BOOT_PC = 32'h0
) (
    input  logic       clk,
    input  logic       reset,

    fe_fetch_if.ctl    fetch,

    // Redirect from execute
    input  logic       br_mispred_valid,
    input  t_rob_id    br_mispred_robid,
    input  t_paddr     br_mispred_restore_pc,

    input  logic       nuke,
    input  logic       resume_fetch,
    input  t_rob_id    oldest_robid,

    // To the decode queue
    output logic       valid_fe1,
    output t_instr_pkt instr_fe1,
    input  logic       ready_fe1,
    output logic       flush
);

    t_fsm_fe state;
    t_fsm_fe state_nxt;
    t_paddr  pc;
    t_paddr  pc_nxt;
    t_paddr  pc_seq;         // Successor of the instruction at pc
    t_paddr  pred_pc;
    logic    pred_tkn;
    logic    adv_pc;
    logic    mispred_ql;
    logic    mispred_pdg;
    t_rob_id mispred_robid;  // Id of the pending mispredict

    // Only the oldest mispredict wins
    assign mispred_ql = br_mispred_valid &
                        (~mispred_pdg |
                         f_robid_a_older_b(br_mispred_robid, mispred_robid, oldest_robid));

    always_ff @(posedge clk) begin
        if (reset) begin
            mispred_pdg <= 1'b0;
        end else begin
            mispred_pdg <= ~nuke & (mispred_pdg | mispred_ql);
        end
    end

    always_ff @(posedge clk) begin
        if (mispred_ql) begin
            mispred_robid <= br_mispred_robid;
        end
    end

    assign flush = mispred_ql | nuke;

    always_comb begin
        state_nxt = state;
        case (state)
            FE_IDLE:    state_nxt = flush ? FE_PDG_RSM : FE_REQ_IC;
            FE_REQ_IC:  if (flush) state_nxt = FE_PDG_RSM;
            FE_PDG_RSM: begin
                // A fresh redirect keeps us parked
                if (resume_fetch & ~flush) state_nxt = FE_REQ_IC;
            end
            default:    state_nxt = FE_IDLE;
        endcase
        if (reset) state_nxt = FE_IDLE;
    end

    always_ff @(posedge clk) begin
        state <= state_nxt;
    end

    bpu u_bpu (
        .instr    (fetch.rsp_instr),
        .pc       (pc),
        .pred_tkn (pred_tkn),
        .pred_pc  (pred_pc)
    );

    assign adv_pc = valid_fe1 & ready_fe1;
    assign pc_seq = pred_tkn ? pred_pc : pc + 32'd4;

    always_comb begin
        if (reset)           pc_nxt = BOOT_PC;
        else if (mispred_ql) pc_nxt = br_mispred_restore_pc;
        else if (adv_pc)     pc_nxt = pc_seq;
        else                 pc_nxt = pc;  // Stalled, refetch same address
    end

    always_ff @(posedge clk) begin
        pc <= pc_nxt;
    end

    // Ask for next cycle's pc now so the response lines up with it
    assign fetch.req_valid = state_nxt == FE_REQ_IC;
    assign fetch.req_addr  = pc_nxt;

    // Stale responses fail the pc compare
    assign valid_fe1 = (state == FE_REQ_IC) & fetch.rsp_valid & (fetch.rsp_pc == pc);

    assign instr_fe1.instr  = fetch.rsp_instr;
    assign instr_fe1.pc     = fetch.rsp_pc;
    assign instr_fe1.pc_nxt = pc_seq;

    // Parked cycles stay silent only if the buffer answers real requests
    a_no_fetch_while_parked: assert property (
        @(posedge clk) disable iff (reset)
        fetch.rsp_valid |-> $past(fetch.req_valid) && fetch.rsp_pc == $past(fetch.req_addr)
    ) else $error("fetch response without a matching request");

endmodule

/* rtl/bpu.sv */
`timescale 1ns/1ps

// Static predictor, looks only at the instruction being fetched
module bpu
    import fe_pkg::*;
(
    input  t_rv_instr instr,
    input  t_paddr    pc,
    output logic      pred_tkn,
    output t_paddr    pred_pc
);

    t_opcode opcode;
    t_paddr  imm_j;
    t_paddr  imm_b;

    always_comb begin
        case (instr[6:0])
            OP_JAL:    opcode = OP_JAL;
            OP_BRANCH: opcode = OP_BRANCH;
            default:   opcode = OP_OTHER;
        endcase
    end

    // J-type immediate
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // B-type immediate
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        pred_tkn = 1'b0;
        pred_pc  = pc + 32'd4;
        case (opcode)
            OP_JAL: begin
                pred_tkn = 1'b1;              // Unconditional
                pred_pc  = pc + imm_j;
            end
            OP_BRANCH: begin
                // Backward taken, forward not taken
                pred_tkn = imm_b[31];
                if (imm_b[31]) begin
                    pred_pc = pc + imm_b;
                end
            end
            default: begin
                pred_tkn = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/imem_fetch_buf.sv */
`timescale 1ns/1ps

// Instruction memory plus the one-cycle fetch buffer in front of it
module imem_fetch_buf
    import fe_pkg::*;
#(
    parameter int IMEM_AW = 8
) (
    input  logic               clk,
    input  logic               reset,

    // External load port, word addressed
    input  logic               imem_we,
    input  logic [IMEM_AW-1:0] imem_waddr,
    input  t_rv_instr          imem_wdata,

    fe_fetch_if.fbuf           fetch
);

    localparam int DEPTH = 1 << IMEM_AW;

    t_rv_instr          mem [DEPTH];
    logic [IMEM_AW-1:0] rd_idx;

    // Drop the byte offset, upper bits alias
    assign rd_idx = fetch.req_addr[IMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (imem_we) begin
            mem[imem_waddr] <= imem_wdata;
        end
    end

    // Response valid follows the request by one edge
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch.rsp_valid <= 1'b0;
        end else begin
            fetch.rsp_valid <= fetch.req_valid;
        end
    end

    // Payload only moves on a real request
    always_ff @(posedge clk) begin
        if (fetch.req_valid) begin
            fetch.rsp_instr <= mem[rd_idx];
            fetch.rsp_pc    <= fetch.req_addr;  // Tag for stale check
        end
    end

endmodule

/* rtl/fe_fetch_if.sv */
`timescale 1ns/1ps

// Fetch request and response between controller and fetch buffer
interface fe_fetch_if
    import fe_pkg::*;
();

    logic      req_valid;
    t_paddr    req_addr;     // Address to fetch, answered next cycle

    logic      rsp_valid;
    t_paddr    rsp_pc;       // Echo of the requested address
    t_rv_instr rsp_instr;

    modport ctl (
        output req_valid,
        output req_addr,
        input  rsp_valid,
        input  rsp_pc,
        input  rsp_instr
    );

    modport fbuf (
        input  req_valid,
        input  req_addr,
        output rsp_valid,
        output rsp_pc,
        output rsp_instr
    );

endinterface

/* rtl/fe_pkg.sv */
package fe_pkg;

    typedef logic [31:0] t_paddr;     // Byte address, word aligned for fetch
    typedef logic [31:0] t_rv_instr;
    typedef logic [3:0]  t_rob_id;    // Wraps at 16

    // Fetch controller states
    typedef enum logic [1:0] {
        FE_IDLE,                      // Out of reset
        FE_REQ_IC,                    // Fetching
        FE_PDG_RSM                    // Stopped, waiting for resume
    } t_fsm_fe;

    // Major opcodes the predictor cares about
    typedef enum logic [6:0] {
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        OP_OTHER  = 7'b0000000        // Anything else
    } t_opcode;

    // One fetched instruction on its way to decode
    typedef struct packed {
        t_rv_instr instr;
        t_paddr    pc;
        t_paddr    pc_nxt;            // Predicted successor
    } t_instr_pkt;

    // ROB ids are compared by distance from the oldest id in flight,
    // so the wrap at 16 does not flip the ordering
    function automatic logic f_robid_a_older_b(
        input t_rob_id a,
        input t_rob_id b,
        input t_rob_id oldest
    );
        t_rob_id age_a;
        t_rob_id age_b;
        age_a = a - oldest;
        age_b = b - oldest;
        return age_a < age_b;
    endfunction

endpackage
